// ==== source/dct_macros.svh ====
`ifndef DCT_MACROS_SVH
`define DCT_MACROS_SVH

// sample and word widths
`define DCT_IN_W 10 // signed input pixel
`define DCT_MID_W 16 // transpose memory word
`define DCT_OUT_W 13 // final coefficient

// transpose memory, one page bit on top of a 6-bit block index
`define DCT_ADDR_W 7

// block geometry
`define DCT_N 8 // points per 1D pass
`define DCT_BLK 64 // samples per 8x8 block

`define DCT_COEF_W 16 // unsigned cosine magnitude

// kept product slice and final shift of each pass
`define DCT_S1_LSB 9
`define DCT_S1_SHIFT 3
`define DCT_S2_LSB 14
`define DCT_S2_SHIFT 8

// row latch to first result out of dct_1d_row
`define DCT_ROW_LAT 6

`endif

// ==== source/dct_pkg.sv ====
`include "dct_macros.svh"

package dct_pkg;

  // one multiplier constant, sign kept apart from the magnitude
  typedef struct packed {
    logic                   neg; // product gets negated
    logic [`DCT_COEF_W-1:0] mag;
  } coef_sm_s;

  // rom stores the flat word, datapath splits it
  typedef union packed {
    logic [`DCT_COEF_W:0] raw;
    coef_sm_s             sm;
  } coef_word_u;

  // four multipliers work on one output at a time
  typedef coef_word_u [`DCT_N/2-1:0] coef_quad_t;

  // output index inside a row, 0..7
  typedef logic [2:0] phase_t;

endpackage

// ==== source/dct_coef_rom.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_coef_rom (
  input  logic                clk,
  input  dct_pkg::phase_t     i_phase,
  output dct_pkg::coef_quad_t o_coef
);
  // cos(k*pi/16) scaled by 2^16
  localparam logic [`DCT_COEF_W-1:0] C4 = 16'd46341;
  localparam logic [`DCT_COEF_W-1:0] S7 = 16'd64277; // = C1
  localparam logic [`DCT_COEF_W-1:0] C3 = 16'd54491;
  localparam logic [`DCT_COEF_W-1:0] S3 = 16'd36410; // = C5
  localparam logic [`DCT_COEF_W-1:0] C7 = 16'd12785;
  localparam logic [`DCT_COEF_W-1:0] S6 = 16'd60547; // = C2
  localparam logic [`DCT_COEF_W-1:0] C6 = 16'd25080;

  function automatic dct_pkg::coef_word_u cw(
    input logic                   neg,
    input logic [`DCT_COEF_W-1:0] mag
  );
    dct_pkg::coef_word_u w;
    w.raw = {neg, mag}; // sign on top
    return w;
  endfunction

  // entries listed from multiplier 3 down to multiplier 0
  // multiplier j works on the pair (x_j, x_7-j)
  always_ff @(posedge clk) begin
    case (i_phase)
      3'd0: o_coef <= {cw(1'b0, C4), cw(1'b0, C4), cw(1'b0, C4), cw(1'b0, C4)}; // dc
      3'd1: o_coef <= {cw(1'b0, C7), cw(1'b0, S3), cw(1'b0, C3), cw(1'b0, S7)};
      3'd2: o_coef <= {cw(1'b1, S6), cw(1'b1, C6), cw(1'b0, C6), cw(1'b0, S6)};
      3'd3: o_coef <= {cw(1'b1, S3), cw(1'b1, S7), cw(1'b1, C7), cw(1'b0, C3)};
      3'd4: o_coef <= {cw(1'b0, C4), cw(1'b1, C4), cw(1'b1, C4), cw(1'b0, C4)};
      3'd5: o_coef <= {cw(1'b0, C3), cw(1'b0, C7), cw(1'b1, S7), cw(1'b0, S3)};
      3'd6: o_coef <= {cw(1'b1, C6), cw(1'b0, S6), cw(1'b1, S6), cw(1'b0, C6)};
      default: o_coef <= {cw(1'b1, S7), cw(1'b0, C3), cw(1'b1, S3), cw(1'b0, C7)}; // k=7
    endcase
  end

endmodule

// ==== source/dct_1d_row.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_1d_row #(
  parameter int IN_W      = 10,
  parameter int OUT_W     = 16,
  parameter int PROD_LSB  = 9,
  parameter int RND_SHIFT = 3
) (
  input  logic                       clk,
  input  logic signed [IN_W-1:0]     i_data,
  input  logic                       i_latch, // 8 samples of a row in sr
  input  logic                       i_odd,   // difference instead of sum
  input  dct_pkg::coef_quad_t        i_coef,
  output logic signed [OUT_W-1:0]    o_data
);
  localparam int NP     = `DCT_N / 2; // butterfly pairs
  localparam int SUM_W  = IN_W + 1; // pair sum, no overflow
  localparam int PROD_W = SUM_W + `DCT_COEF_W; // full magnitude product
  localparam int SL_W   = PROD_W - PROD_LSB; // kept upper slice
  localparam int P_W    = SL_W + 1; // slice with sign back on
  localparam int ACC_W  = P_W + 2; // after the 4-input adder tree
  localparam int RND_W  = ACC_W - RND_SHIFT;

  logic signed [IN_W-1:0]  sr [`DCT_N]; // sr[0] newest
  logic signed [IN_W-1:0]  xr [`DCT_N]; // held row, xr[N-1] is x0
  logic signed [SUM_W-1:0] bfly [NP];
  logic [SUM_W-1:0]        mag [NP];
  logic                    neg [NP]; // sign of the sum/difference
  logic [PROD_W-1:0]       full [NP];
  logic signed [P_W-1:0]   prod [NP];
  logic signed [ACC_W-2:0] acc_a;
  logic signed [ACC_W-2:0] acc_b;
  logic signed [ACC_W-1:0] acc;
  logic signed [RND_W-1:0] rnd;

  // input shift and row capture
  always_ff @(posedge clk) begin
    sr[0] <= i_data;
    for (int i = 1; i < `DCT_N; i++) begin
      sr[i] <= sr[i-1];
    end
    if (i_latch) begin
      xr <= sr; // stays put for the 8 outputs of the row
    end
  end

  // butterfly, pair j is (x_j, x_7-j)
  always_ff @(posedge clk) begin
    for (int j = 0; j < NP; j++) begin
      if (i_odd) begin
        bfly[j] <= xr[`DCT_N-1-j] - xr[j]; // x_j - x_7-j
      end else begin
        bfly[j] <= xr[`DCT_N-1-j] + xr[j];
      end
    end
  end

  // sign-magnitude split, -2^IN_W still fits the unsigned magnitude
  always_ff @(posedge clk) begin
    for (int j = 0; j < NP; j++) begin
      neg[j] <= bfly[j][SUM_W-1];
      mag[j] <= bfly[j][SUM_W-1] ? -bfly[j] : bfly[j];
    end
  end

  always_comb begin
    for (int j = 0; j < NP; j++) begin
      full[j] = mag[j] * i_coef[j].sm.mag; // unsigned multiply
    end
  end

  // drop low bits of the magnitude, i.e. truncate toward zero
  always_ff @(posedge clk) begin
    for (int j = 0; j < NP; j++) begin
      if (neg[j] ^ i_coef[j].sm.neg) begin
        prod[j] <= -$signed({1'b0, full[j][PROD_W-1:PROD_LSB]});
      end else begin
        prod[j] <= $signed({1'b0, full[j][PROD_W-1:PROD_LSB]});
      end
    end
  end

  // two-level adder tree
  always_ff @(posedge clk) begin
    acc_a <= prod[0] + prod[1];
    acc_b <= prod[2] + prod[3];
    acc   <= acc_a + acc_b;
  end

  // round half up: add back the last bit shifted out
  assign rnd    = acc[ACC_W-1:RND_SHIFT] + acc[RND_SHIFT-1];
  assign o_data = rnd[OUT_W-1:0]; // upper bits wrap

endmodule

// ==== source/dct_in_ctrl.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_in_ctrl (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_en,
  input  logic                   i_start,
  output logic                   o_latch,
  output logic                   o_odd,
  output dct_pkg::phase_t        o_phase,
  output logic                   o_we,
  output logic [`DCT_ADDR_W-1:0] o_waddr,
  output logic                   o_last_in,
  output logic                   o_done,
  output logic                   o_page
);
  localparam int LD = `DCT_ROW_LAT - 1; // latch to we register input

  logic [`DCT_ADDR_W-2:0] in_cnt; // index of the sample now on the input
  logic                   in_busy;
  logic [LD-1:0]          lat_sr;
  logic [`DCT_ADDR_W-1:0] wr_addr; // {page, row, k}
  dct_pkg::phase_t        ph;

  assign o_last_in = in_busy && (in_cnt == (`DCT_ADDR_W-1)'(`DCT_BLK - 1));
  assign o_done    = o_we && (wr_addr[`DCT_ADDR_W-2:0] == (`DCT_ADDR_W-1)'(`DCT_BLK - 1));
  assign o_page    = wr_addr[`DCT_ADDR_W-1]; // page of the block being written
  assign o_waddr   = wr_addr;
  assign o_odd     = ph[0];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_cnt  <= '0;
      in_busy <= 1'b0;
      o_latch <= 1'b0;
      lat_sr  <= '0;
      o_we    <= 1'b0;
      wr_addr <= '0;
    end else if (!i_en) begin
      in_cnt  <= '0;
      in_busy <= 1'b0;
      o_latch <= 1'b0;
      lat_sr  <= '0;
      o_we    <= 1'b0;
      wr_addr <= '0; // back to page 0
    end else begin
      if (i_start) begin
        in_cnt  <= 1; // sample 0 is on the input now
        in_busy <= 1'b1;
      end else if (in_busy) begin
        in_cnt  <= in_cnt + 1'b1;
        in_busy <= !o_last_in;
      end
      o_latch <= in_busy && (in_cnt[2:0] == 3'd7); // row complete in sr
      lat_sr  <= {lat_sr[LD-2:0], o_latch};
      // 8 writes per row, runs on if the next row is already due
      o_we <= lat_sr[LD-1] || (o_we && (wr_addr[2:0] != 3'd7));
      if (o_we) begin
        wr_addr <= wr_addr + 1'b1; // carry into msb flips the page
      end
    end
  end

  // phase restarts with each row, else free running
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ph      <= '0;
      o_phase <= '0;
    end else begin
      ph      <= o_latch ? '0 : ph + 1'b1;
      o_phase <= ph; // rom adds one more cycle
    end
  end

endmodule

// ==== source/dct_out_ctrl.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_out_ctrl (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_en,
  input  logic                   i_start, // last write of stage one
  input  logic                   i_page,
  output logic [`DCT_ADDR_W-1:0] o_raddr,
  output logic                   o_latch,
  output logic                   o_odd,
  output dct_pkg::phase_t        o_phase,
  output logic                   o_dv,
  output logic                   o_pre_first_out
);
  // 1 read, 8 samples, 1 latch, then the row pipeline
  localparam int PRE_DLY = 9 + `DCT_ROW_LAT;

  logic                   rd_page;
  logic [`DCT_ADDR_W-2:0] rd_cnt; // {column, row}
  logic                   rd_busy;
  logic                   rd_end;
  logic                   lat_p; // column read, data one cycle behind
  logic [PRE_DLY-1:0]     start_sr;
  logic [PRE_DLY-1:0]     end_sr;
  dct_pkg::phase_t        ph;

  assign rd_end          = rd_busy && (rd_cnt == '1);
  assign o_raddr         = {rd_page, rd_cnt[2:0], rd_cnt[5:3]}; // transposed
  assign o_pre_first_out = start_sr[PRE_DLY-1];
  assign o_odd           = ph[0];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_page  <= 1'b0;
      rd_cnt   <= '0;
      rd_busy  <= 1'b0;
      lat_p    <= 1'b0;
      o_latch  <= 1'b0;
      start_sr <= '0;
      end_sr   <= '0;
      o_dv     <= 1'b0;
    end else if (!i_en) begin
      rd_page  <= 1'b0;
      rd_cnt   <= '0;
      rd_busy  <= 1'b0;
      lat_p    <= 1'b0;
      o_latch  <= 1'b0;
      start_sr <= '0;
      end_sr   <= '0;
      o_dv     <= 1'b0;
    end else begin
      if (i_start) begin
        rd_page <= i_page; // page just filled
        rd_cnt  <= '0;
        rd_busy <= 1'b1;
      end else if (rd_busy) begin
        rd_cnt  <= rd_cnt + 1'b1;
        rd_busy <= !rd_end;
      end
      lat_p    <= rd_busy && (rd_cnt[2:0] == 3'd7);
      o_latch  <= lat_p; // memory read latency
      start_sr <= {start_sr[PRE_DLY-2:0], i_start};
      end_sr   <= {end_sr[PRE_DLY-2:0], rd_end};
      // stays high across back-to-back blocks
      o_dv <= o_pre_first_out || (o_dv && !end_sr[PRE_DLY-1]);
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ph      <= '0;
      o_phase <= '0;
    end else begin
      ph      <= o_latch ? '0 : ph + 1'b1;
      o_phase <= ph;
    end
  end

endmodule

// ==== source/dct_transpose_mem.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_transpose_mem (
  input  logic                   clk,
  input  logic                   i_we,
  input  logic [`DCT_ADDR_W-1:0] i_waddr,
  input  logic [`DCT_MID_W-1:0]  i_wdata,
  input  logic [`DCT_ADDR_W-1:0] i_raddr,
  output logic [`DCT_MID_W-1:0]  o_rdata
);
  // two pages of one block each
  logic [`DCT_MID_W-1:0] mem [2*`DCT_BLK];

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_raddr]; // registered read, one cycle
  end

endmodule

// ==== source/dct_2d.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_2d (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_en,
  input  logic                  i_start, // with first sample of a block
  input  logic [`DCT_IN_W-1:0]  i_xin,
  output logic                  o_last_in,
  output logic                  o_pre_first_out,
  output logic                  o_dv,
  output logic [`DCT_OUT_W-1:0] o_d_out // column-major order
);
  // stage one side
  logic                   s1_latch;
  logic                   s1_odd;
  dct_pkg::phase_t        s1_phase;
  dct_pkg::coef_quad_t    s1_coef;
  logic                   tm_we;
  logic [`DCT_ADDR_W-1:0] tm_waddr;
  logic [`DCT_MID_W-1:0]  tm_wdata;
  logic                   s1_done;
  logic                   s1_page;
  // stage two side
  logic [`DCT_ADDR_W-1:0] tm_raddr;
  logic [`DCT_MID_W-1:0]  tm_rdata;
  logic                   s2_latch;
  logic                   s2_odd;
  dct_pkg::phase_t        s2_phase;
  dct_pkg::coef_quad_t    s2_coef;

  dct_in_ctrl dct_in_ctrl_inst (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_en      (i_en),
    .i_start   (i_start),
    .o_latch   (s1_latch),
    .o_odd     (s1_odd),
    .o_phase   (s1_phase),
    .o_we      (tm_we),
    .o_waddr   (tm_waddr),
    .o_last_in (o_last_in),
    .o_done    (s1_done),
    .o_page    (s1_page)
  );

  dct_coef_rom s1_rom_inst (
    .clk     (clk),
    .i_phase (s1_phase),
    .o_coef  (s1_coef)
  );

  // rows: 10-bit pixels in, 16-bit words to the transpose memory
  dct_1d_row #(
    .IN_W      (`DCT_IN_W),
    .OUT_W     (`DCT_MID_W),
    .PROD_LSB  (`DCT_S1_LSB),
    .RND_SHIFT (`DCT_S1_SHIFT)
  ) s1_row_inst (
    .clk     (clk),
    .i_data  (i_xin),
    .i_latch (s1_latch),
    .i_odd   (s1_odd),
    .i_coef  (s1_coef),
    .o_data  (tm_wdata)
  );

  dct_transpose_mem dct_transpose_mem_inst (
    .clk     (clk),
    .i_we    (tm_we),
    .i_waddr (tm_waddr),
    .i_wdata (tm_wdata),
    .i_raddr (tm_raddr),
    .o_rdata (tm_rdata)
  );

  dct_out_ctrl dct_out_ctrl_inst (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_en            (i_en),
    .i_start         (s1_done),
    .i_page          (s1_page),
    .o_raddr         (tm_raddr),
    .o_latch         (s2_latch),
    .o_odd           (s2_odd),
    .o_phase         (s2_phase),
    .o_dv            (o_dv),
    .o_pre_first_out (o_pre_first_out)
  );

  dct_coef_rom s2_rom_inst (
    .clk     (clk),
    .i_phase (s2_phase),
    .o_coef  (s2_coef)
  );

  // columns: transposed words in, 13-bit coefficients out
  dct_1d_row #(
    .IN_W      (`DCT_MID_W),
    .OUT_W     (`DCT_OUT_W),
    .PROD_LSB  (`DCT_S2_LSB),
    .RND_SHIFT (`DCT_S2_SHIFT)
  ) s2_row_inst (
    .clk     (clk),
    .i_data  (tm_rdata),
    .i_latch (s2_latch),
    .i_odd   (s2_odd),
    .i_coef  (s2_coef),
    .o_data  (o_d_out)
  );

endmodule

// ==== tests/dct_checker.sv ====
`timescale 1ns/1ps

module dct_checker (
  input logic clk,
  input logic i_rst_n,
  input logic i_en,
  input logic i_start,
  input logic i_last_in,
  input logic i_pre_first_out,
  input logic i_dv
);
  int fail_cnt = 0; // read by the testbench at the end

  // marker one cycle ahead of a full block of coefficients
  pre_leads_dv: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pre_first_out |=> i_dv [*64])
    else begin
      $error("o_dv not high for 64 cycles after o_pre_first_out");
      fail_cnt++;
    end

  dv_known: assert property (@(posedge clk) disable iff (!i_rst_n)
    !$isunknown(i_dv))
    else begin
      $error("o_dv is unknown after reset");
      fail_cnt++;
    end

  // 64th sample sits 63 cycles behind the start pulse
  last_after_start: assert property (@(posedge clk) disable iff (!i_rst_n || !i_en)
    i_start |-> ##63 i_last_in)
    else begin
      $error("o_last_in missing 63 cycles after i_start");
      fail_cnt++;
    end

endmodule

bind dct_2d dct_checker dct_checker_inst (
  .clk             (clk),
  .i_rst_n         (i_rst_n),
  .i_en            (i_en),
  .i_start         (i_start),
  .i_last_in       (o_last_in),
  .i_pre_first_out (o_pre_first_out),
  .i_dv            (o_dv)
);

// ==== tests/dct_monitor.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module dct_monitor (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_en,
  input  logic                  i_start,
  input  logic [`DCT_IN_W-1:0]  i_xin,
  input  logic                  i_last_in,
  input  logic                  i_pre_first_out,
  input  logic                  i_dv,
  input  logic [`DCT_OUT_W-1:0] i_d_out,
  input  int                    i_test_id,
  output int                    o_err_cnt,
  output int                    o_dv_cnt,
  output int                    o_pending
);
  longint row_buf [8]; // one 8-point vector for a 1D pass
  longint blk [64]; // captured input block, row-major
  longint mid [64]; // row results after the 16-bit wrap
  longint exp_q [$]; // expected coefficients, column-major
  int     id_q [$]; // test id of each expected entry
  int     in_idx  = -1; // sample index in block, -1 idle
  int     blk_id  = 0; // test id of the block being captured
  int     out_idx = 0;
  logic   pre_d   = 1'b0; // o_pre_first_out one cycle back
  int     err_cnt = 0;
  int     dv_cnt  = 0;
  int     pending = 0;

  assign o_err_cnt = err_cnt;
  assign o_dv_cnt  = dv_cnt;
  assign o_pending = pending;

  function automatic string test_name(input int id);
    case (id)
      0: return "random";
      1: return "constant";
      2: return "all_max";
      3: return "all_min";
      4: return "checkerboard";
      5: return "back_to_back";
      default: return "random_gaps";
    endcase
  endfunction

  // |cos(i*pi/16)| in 2^16 units
  function automatic longint cos_mag(input int i);
    case (i)
      1: return 64277;
      2: return 60547;
      3: return 54491;
      4: return 46341;
      5: return 36410;
      6: return 25080;
      7: return 12785;
      default: return 0;
    endcase
  endfunction

  // signed cos((2j+1)k pi/16), dc row scaled by cos(pi/4)
  function automatic longint coef(input int k, input int j);
    int m;
    m = ((2 * j + 1) * k) % 32;
    if (k == 0) return cos_mag(4);
    else if (m <= 8) return cos_mag(m);
    else if (m <= 16) return -cos_mag(16 - m);
    else if (m <= 24) return -cos_mag(m - 16);
    else return cos_mag(32 - m);
  endfunction

  // output k of row_buf, sign-magnitude products then round half up
  function automatic longint dct_point(input int k, input int lsb, input int shift);
    longint acc;
    longint s;
    longint c;
    longint p;
    acc = 0;
    for (int j = 0; j < 4; j++) begin
      s = (k % 2) ? row_buf[j] - row_buf[7-j] : row_buf[j] + row_buf[7-j];
      c = coef(k, j);
      p = ((s < 0 ? -s : s) * (c < 0 ? -c : c)) >> lsb; // magnitude truncated
      if ((s < 0) != (c < 0)) p = -p;
      acc += p;
    end
    return (acc >>> shift) + ((acc >>> (shift - 1)) & 1);
  endfunction

  function automatic longint wrap(input longint v, input int w);
    longint m;
    m = v & ((64'sd1 <<< w) - 1);
    if (m >= (64'sd1 <<< (w - 1))) m -= (64'sd1 <<< w);
    return m;
  endfunction

  task automatic build_expected(input int id);
    for (int r = 0; r < 8; r++) begin
      for (int n = 0; n < 8; n++) row_buf[n] = blk[r*8 + n];
      for (int k = 0; k < 8; k++) begin
        mid[r*8 + k] = wrap(dct_point(k, `DCT_S1_LSB, `DCT_S1_SHIFT), `DCT_MID_W);
      end
    end
    // column u gives Y[0..7][u]
    for (int u = 0; u < 8; u++) begin
      for (int n = 0; n < 8; n++) row_buf[n] = mid[n*8 + u];
      for (int v = 0; v < 8; v++) begin
        exp_q.push_back(wrap(dct_point(v, `DCT_S2_LSB, `DCT_S2_SHIFT), `DCT_OUT_W));
        id_q.push_back(id);
      end
    end
  endtask

  always @(posedge clk) begin
    longint expv;
    int     id;
    if (!i_rst_n) begin
      if (i_dv || i_pre_first_out || i_last_in) begin
        $display("control output high during reset at %0t", $time);
        err_cnt++;
      end
      in_idx  = -1;
      out_idx = 0;
      pre_d   = 1'b0;
    end else begin
      if (i_en && i_start) begin
        in_idx = 0; // first sample of a block
        blk_id = i_test_id;
      end else if (in_idx >= 0) begin
        in_idx++;
      end
      if (i_last_in !== (in_idx == 63)) begin
        $display("o_last_in wrong at input sample %0d, time %0t", in_idx, $time);
        err_cnt++;
      end
      if (in_idx >= 0) begin
        blk[in_idx] = $signed(i_xin);
        if (in_idx == 63) begin
          build_expected(blk_id);
          in_idx = -1;
        end
      end
      if (i_dv) begin
        if (exp_q.size() == 0) begin
          $display("o_dv high with no coefficient expected, time %0t", $time);
          err_cnt++;
        end else begin
          expv = exp_q.pop_front();
          id   = id_q.pop_front();
          if (pre_d != (out_idx == 0)) begin
            $display("o_pre_first_out did not lead coefficient 0 (index %0d)", out_idx);
            err_cnt++;
          end
          if ($isunknown(i_d_out) || longint'($signed(i_d_out)) != expv) begin
            $display("[FAIL] %s n=%0d expected %0d actual %0d",
                     test_name(id), out_idx, expv, $signed(i_d_out));
            err_cnt++;
          end
          out_idx = (out_idx + 1) % 64;
        end
        dv_cnt++;
      end else if (pre_d) begin
        $display("o_pre_first_out not followed by o_dv, time %0t", $time);
        err_cnt++;
      end
      pre_d   = i_pre_first_out;
      pending = exp_q.size();
    end
  end

endmodule

// ==== tests/dct_tb.sv ====
`timescale 1ns/1ps
`include "dct_macros.svh"

module tb_dct_2d;
  localparam int N_BLOCKS = 17; // 5 single + 6 back to back + 6 gapped
  localparam int MAX_GAP  = 20;
  localparam int LIMIT    = N_BLOCKS * (`DCT_BLK + MAX_GAP) + 400;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_en;
  logic                  i_start;
  logic [`DCT_IN_W-1:0]  i_xin;
  logic                  o_last_in;
  logic                  o_pre_first_out;
  logic                  o_dv;
  logic [`DCT_OUT_W-1:0] o_d_out;

  logic [`DCT_IN_W-1:0] blk_data [64]; // next block to send
  int test_id;
  int seed;
  int gap;
  int cycles = 0;
  int tb_err = 0;
  int chk_err;
  int err_cnt;
  int dv_cnt;
  int pending;

  dct_2d dct_2d_inst (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_en            (i_en),
    .i_start         (i_start),
    .i_xin           (i_xin),
    .o_last_in       (o_last_in),
    .o_pre_first_out (o_pre_first_out),
    .o_dv            (o_dv),
    .o_d_out         (o_d_out)
  );

  dct_monitor dct_monitor_inst (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_en            (i_en),
    .i_start         (i_start),
    .i_xin           (i_xin),
    .i_last_in       (o_last_in),
    .i_pre_first_out (o_pre_first_out),
    .i_dv            (o_dv),
    .i_d_out         (o_d_out),
    .i_test_id       (test_id),
    .o_err_cnt       (err_cnt),
    .o_dv_cnt        (dv_cnt),
    .o_pending       (pending)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk; // 20 ns period

  // run length guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, o_dv output did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic fill_random();
    for (int n = 0; n < 64; n++) blk_data[n] = $random(seed) % 512; // within +-511
  endtask

  task automatic fill_const(input int v);
    for (int n = 0; n < 64; n++) blk_data[n] = v[`DCT_IN_W-1:0];
  endtask

  task automatic fill_checker();
    for (int n = 0; n < 64; n++) begin
      blk_data[n] = (((n >> 3) ^ n) & 1) ? -10'sd512 : 10'sd511;
    end
  endtask

  // 64 samples on consecutive cycles, then idle cycles
  task automatic send_block(input int id, input int gap_cycles);
    test_id = id;
    for (int n = 0; n < 64; n++) begin
      @(posedge clk);
      #1;
      i_start = (n == 0);
      i_xin   = blk_data[n];
    end
    for (int g = 0; g < gap_cycles; g++) begin
      @(posedge clk);
      #1;
      i_xin = '0;
    end
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_en    = 1'b0;
    i_start = 1'b0;
    i_xin   = '0;
    test_id = 0;
    seed    = 79;
    repeat (4) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    i_en    = 1'b1;

    fill_random();
    send_block(0, 3);
    fill_const(137);
    send_block(1, 5);
    fill_const(511);
    send_block(2, 0);
    fill_const(-512);
    send_block(3, 0);
    fill_checker();
    send_block(4, 10);
    repeat (6) begin
      fill_random();
      send_block(5, 0);
    end
    repeat (6) begin
      gap = $unsigned($random(seed)) % (MAX_GAP + 1);
      fill_random();
      send_block(6, gap);
    end

    wait (pending == 0 && dv_cnt == N_BLOCKS * `DCT_BLK);
    repeat (40) @(posedge clk); // catch stray o_dv
    if (dv_cnt != N_BLOCKS * `DCT_BLK) begin
      $display("o_dv count %0d, wanted %0d", dv_cnt, N_BLOCKS * `DCT_BLK);
      tb_err++;
    end
    chk_err = dct_2d_inst.dct_checker_inst.fail_cnt;
    $display("errors: %0d total, monitor %0d, assertions %0d, testbench %0d",
             err_cnt + chk_err + tb_err, err_cnt, chk_err, tb_err);
    if (err_cnt + chk_err + tb_err == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
source/dct_pkg.sv
source/dct_coef_rom.sv
source/dct_1d_row.sv
source/dct_in_ctrl.sv
source/dct_out_ctrl.sv
source/dct_transpose_mem.sv
source/dct_2d.sv
tests/dct_checker.sv
tests/dct_monitor.sv
tests/dct_tb.sv

// ==== Bender.yml ====
package:
  name: dct_2d

export_include_dirs:
  - source

sources:
  - source/dct_pkg.sv
  - source/dct_coef_rom.sv
  - source/dct_1d_row.sv
  - source/dct_in_ctrl.sv
  - source/dct_out_ctrl.sv
  - source/dct_transpose_mem.sv
  - source/dct_2d.sv
  - target: test
    files:
      - tests/dct_checker.sv
      - tests/dct_monitor.sv
      - tests/dct_tb.sv
